// File: Bender.yml
package:
  name: rv32i_soc_core

sources:
  - files:
      - hw/rv_core_pkg.sv
      - hw/unified_ram.sv
      - hw/mem_arbiter.sv
      - hw/fetch_unit.sv
      - hw/decode_unit.sv
      - hw/exec_unit.sv
      - hw/mem_stage.sv
      - hw/soc_core_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_soc_core.sv

// File: hw/decode_unit.sv
// unknown opcodes decode as bubbles; OP_IMM funct3 other than ADDI maps onto the ALU ops too
`timescale 1ns/100ps
`default_nettype none

module decode_unit import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  if_id_t    if_id_i,
    input  redirect_t redirect_i,
    input  ex_mem_t   ex_fwd_i,
    input  wb_t       mem_fwd_i,
    input  wb_t       wb_i,
    output logic      hold_o,
    output id_ex_t    id_ex_o
);

    word_t      rf_q [1:31];
    opcode_e    opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      imm_i;
    logic       use_rs1;
    logic       use_rs2;
    id_ex_t     id_ex_d;

    // EX result first, then MEM, then the write in flight, then the file
    function automatic word_t read_src(reg_addr_t rs);
        word_t val;
        val = '0;
        if (rs != '0) begin
            if (ex_fwd_i.valid && ex_fwd_i.rd_we && ex_fwd_i.rd == rs)
                val = ex_fwd_i.result;
            else if (mem_fwd_i.valid && mem_fwd_i.rd == rs)
                val = mem_fwd_i.data;
            else if (wb_i.valid && wb_i.rd == rs)
                val = wb_i.data;
            else
                val = rf_q[rs];
        end
        return val;
    endfunction

    always_comb begin
        opcode  = opcode_e'(if_id_i.inst[6:0]);
        funct3  = if_id_i.inst[14:12];
        rs1     = if_id_i.inst[19:15];
        rs2     = if_id_i.inst[24:20];
        imm_i   = {{20{if_id_i.inst[31]}}, if_id_i.inst[31:20]};
        use_rs1 = opcode inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH};
        use_rs2 = opcode inside {OPC_OP, OPC_STORE, OPC_BRANCH};

        // load result not ready until MEM
        hold_o = if_id_i.valid && ex_fwd_i.valid && ex_fwd_i.load && ex_fwd_i.rd != '0
                 && ((use_rs1 && rs1 == ex_fwd_i.rd) || (use_rs2 && rs2 == ex_fwd_i.rd));

        id_ex_d       = '0;
        id_ex_d.valid = if_id_i.valid;
        id_ex_d.pc    = if_id_i.pc;
        id_ex_d.rd    = if_id_i.inst[11:7];
        id_ex_d.op_a  = read_src(rs1);
        id_ex_d.op_b  = (opcode == OPC_OP_IMM) ? imm_i : read_src(rs2);
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                id_ex_d.rd_we = 1'b1;
                id_ex_d.imm   = imm_i;
                case (funct3)
                    3'b100:  id_ex_d.alu_op = ALU_XOR;
                    3'b110:  id_ex_d.alu_op = ALU_OR;
                    3'b111:  id_ex_d.alu_op = ALU_AND;
                    default: id_ex_d.alu_op = (opcode == OPC_OP && if_id_i.inst[30]) ?
                                              ALU_SUB : ALU_ADD;
                endcase
            end
            OPC_LOAD: begin
                id_ex_d.rd_we = 1'b1;
                id_ex_d.load  = 1'b1;
                id_ex_d.imm   = imm_i;
            end
            OPC_STORE: begin
                id_ex_d.store = 1'b1;
                id_ex_d.imm   = {{20{if_id_i.inst[31]}}, if_id_i.inst[31:25], if_id_i.inst[11:7]};
            end
            OPC_BRANCH: begin
                id_ex_d.branch = 1'b1;
                id_ex_d.bne    = funct3[0];
                id_ex_d.imm    = {{19{if_id_i.inst[31]}}, if_id_i.inst[31], if_id_i.inst[7],
                                  if_id_i.inst[30:25], if_id_i.inst[11:8], 1'b0};
            end
            OPC_JAL: begin
                id_ex_d.jal   = 1'b1;
                id_ex_d.rd_we = 1'b1;
                id_ex_d.imm   = {{11{if_id_i.inst[31]}}, if_id_i.inst[31], if_id_i.inst[19:12],
                                 if_id_i.inst[20], if_id_i.inst[30:21], 1'b0};
            end
            default: id_ex_d.valid = 1'b0;
        endcase
    end

    // x0 has no storage
    always_ff @(posedge clk) begin
        if (wb_i.valid)
            rf_q[wb_i.rd] <= wb_i.data;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            id_ex_o <= '0;
        else if (redirect_i.valid || hold_o)
            id_ex_o.valid <= 1'b0;
        else
            id_ex_o <= id_ex_d;
    end

endmodule

`default_nettype wire

// File: hw/exec_unit.sv
// branches and JAL resolve here; a taken one costs two bubbles
`timescale 1ns/100ps
`default_nettype none

module exec_unit import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  id_ex_t    id_ex_i,
    output ex_mem_t   ex_fwd_o,
    output redirect_t redirect_o,
    output ex_mem_t   ex_mem_o
);

    word_t alu_res;
    logic  equal;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SUB: alu_res = id_ex_i.op_a - id_ex_i.op_b;
            ALU_AND: alu_res = id_ex_i.op_a & id_ex_i.op_b;
            ALU_OR:  alu_res = id_ex_i.op_a | id_ex_i.op_b;
            ALU_XOR: alu_res = id_ex_i.op_a ^ id_ex_i.op_b;
            default: alu_res = id_ex_i.op_a + id_ex_i.op_b;
        endcase
    end

    always_comb begin
        equal = (id_ex_i.op_a == id_ex_i.op_b);

        // BNE takes the branch on inequality
        redirect_o.valid  = id_ex_i.valid &&
                            (id_ex_i.jal || (id_ex_i.branch && (equal != id_ex_i.bne)));
        redirect_o.target = id_ex_i.pc + id_ex_i.imm;

        ex_fwd_o.valid      = id_ex_i.valid;
        ex_fwd_o.rd         = id_ex_i.rd;
        ex_fwd_o.rd_we      = id_ex_i.rd_we;
        ex_fwd_o.load       = id_ex_i.load;
        ex_fwd_o.store      = id_ex_i.store;
        ex_fwd_o.store_data = id_ex_i.op_b;
        if (id_ex_i.jal)
            ex_fwd_o.result = id_ex_i.pc + 32'd4;
        else if (id_ex_i.load || id_ex_i.store)
            ex_fwd_o.result = id_ex_i.op_a + id_ex_i.imm;
        else
            ex_fwd_o.result = alu_res;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            ex_mem_o <= '0;
        else if (ex_fwd_o.valid)
            ex_mem_o <= ex_fwd_o;
        else
            ex_mem_o.valid <= 1'b0;
    end

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
// PC must be word aligned; a fetch that loses arbitration leaves a bubble in IF/ID
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import rv_core_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      run_i,
    input  logic      fetch_gnt_i,
    input  word_t     fetch_rdata_i,
    input  logic      hold_i,
    input  redirect_t redirect_i,
    output mem_req_t  fetch_req_o,
    output if_id_t    if_id_o
);

    word_t pc_q;

    // skip the request when the fetched word would be dropped anyway
    always_comb begin
        fetch_req_o       = '0;
        fetch_req_o.req   = run_i && !hold_i && !redirect_i.valid;
        fetch_req_o.addr  = {2'b00, pc_q[XLEN-1:2]};
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q    <= RESET_PC;
            if_id_o <= '0;
        end else if (!run_i) begin
            pc_q          <= RESET_PC;
            if_id_o.valid <= 1'b0;
        end else if (redirect_i.valid) begin
            pc_q          <= redirect_i.target;
            if_id_o.valid <= 1'b0;
        end else if (!hold_i) begin
            if (fetch_gnt_i) begin
                pc_q          <= pc_q + 32'd4;
                if_id_o.valid <= 1'b1;
                if_id_o.pc    <= pc_q;
                if_id_o.inst  <= fetch_rdata_i;
            end else begin
                // lost the RAM to host or data
                if_id_o.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_arbiter.sv
// host then data then fetch; only fetch ever loses, addresses wrap at MEM_WORDS
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import rv_core_pkg::*; #(
    parameter int unsigned MEM_WORDS = 1024
) (
    input  mem_req_t host_req_i,
    input  mem_req_t data_req_i,
    input  mem_req_t fetch_req_i,
    output logic     fetch_gnt_o,
    output mem_req_t ram_req_o
);

    mem_req_t sel;

    always_comb begin
        fetch_gnt_o = 1'b0;
        if (host_req_i.req) begin
            sel = host_req_i;
        end else if (data_req_i.req) begin
            sel = data_req_i;
        end else begin
            sel         = fetch_req_i;
            fetch_gnt_o = fetch_req_i.req;
        end

        ram_req_o      = sel;
        ram_req_o.addr = sel.addr % MEM_WORDS;
    end

endmodule

`default_nettype wire

// File: hw/mem_stage.sv
// word accesses only; the two low address bits are dropped
`timescale 1ns/100ps
`default_nettype none

module mem_stage import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  ex_mem_t  ex_mem_i,
    input  word_t    rdata_i,
    output mem_req_t data_req_o,
    output wb_t      mem_fwd_o,
    output wb_t      wb_o
);

    always_comb begin
        data_req_o.req   = ex_mem_i.valid && (ex_mem_i.load || ex_mem_i.store);
        data_req_o.we    = ex_mem_i.valid && ex_mem_i.store;
        data_req_o.addr  = {2'b00, ex_mem_i.result[XLEN-1:2]};
        data_req_o.wdata = ex_mem_i.store_data;

        // writes to x0 never reach the register file or retire
        mem_fwd_o.valid = ex_mem_i.valid && ex_mem_i.rd_we && (ex_mem_i.rd != '0);
        mem_fwd_o.rd    = ex_mem_i.rd;
        mem_fwd_o.data  = ex_mem_i.load ? rdata_i : ex_mem_i.result;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            wb_o <= '0;
        else
            wb_o <= mem_fwd_o;
    end

endmodule

`default_nettype wire

// File: hw/rv_core_pkg.sv
// shared types for the RV32I subset core; all memory addresses in mem_req_t are word addresses
`default_nettype none

package rv_core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes kept in this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef struct packed {
        logic  req;
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        word_t     imm;
        reg_addr_t rd;
        logic      rd_we;
        logic      load;
        logic      store;
        logic      branch;
        logic      bne;
        logic      jal;
    } id_ex_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      rd_we;
        logic      load;
        logic      store;
        word_t     result;
        word_t     store_data;
    } ex_mem_t;

    // register write, valid only for a nonzero rd
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

// File: hw/soc_core_top.sv
// host port strobes only while run_i is low, since the host always wins the RAM over the core
`timescale 1ns/100ps
`default_nettype none

module soc_core_top import rv_core_pkg::*; #(
    parameter int unsigned MEM_WORDS = 1024,
    parameter word_t       RESET_PC  = '0
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     run_i,
    input  mem_req_t host_req_i,
    output word_t    host_rdata_o,
    output wb_t      retire_o
);

    mem_req_t  fetch_req;
    mem_req_t  data_req;
    mem_req_t  ram_req;
    logic      fetch_gnt;
    word_t     ram_rdata;
    logic      hold;
    redirect_t redirect;
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_fwd;
    ex_mem_t   ex_mem;
    wb_t       mem_fwd;
    wb_t       wb;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .run_i         (run_i),
        .fetch_gnt_i   (fetch_gnt),
        .fetch_rdata_i (ram_rdata),
        .hold_i        (hold),
        .redirect_i    (redirect),
        .fetch_req_o   (fetch_req),
        .if_id_o       (if_id)
    );

    decode_unit u_decode (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .if_id_i    (if_id),
        .redirect_i (redirect),
        .ex_fwd_i   (ex_fwd),
        .mem_fwd_i  (mem_fwd),
        .wb_i       (wb),
        .hold_o     (hold),
        .id_ex_o    (id_ex)
    );

    exec_unit u_exec (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .id_ex_i    (id_ex),
        .ex_fwd_o   (ex_fwd),
        .redirect_o (redirect),
        .ex_mem_o   (ex_mem)
    );

    mem_stage u_mem (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .ex_mem_i   (ex_mem),
        .rdata_i    (ram_rdata),
        .data_req_o (data_req),
        .mem_fwd_o  (mem_fwd),
        .wb_o       (wb)
    );

    mem_arbiter #(
        .MEM_WORDS(MEM_WORDS)
    ) u_arb (
        .host_req_i  (host_req_i),
        .data_req_i  (data_req),
        .fetch_req_i (fetch_req),
        .fetch_gnt_o (fetch_gnt),
        .ram_req_o   (ram_req)
    );

    unified_ram #(
        .MEM_WORDS(MEM_WORDS)
    ) u_ram (
        .clk     (clk),
        .req_i   (ram_req),
        .rdata_o (ram_rdata)
    );

    // host read data shows up one cycle after the strobe
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            host_rdata_o <= '0;
        else if (host_req_i.req && !host_req_i.we)
            host_rdata_o <= ram_rdata;
    end

    assign retire_o = wb;

endmodule

`default_nettype wire

// File: hw/unified_ram.sv
// contents are undefined until written; a read sees the old word in a write cycle
`timescale 1ns/100ps
`default_nettype none

module unified_ram import rv_core_pkg::*; #(
    parameter int unsigned MEM_WORDS = 1024
) (
    input  logic     clk,
    input  mem_req_t req_i,
    output word_t    rdata_o
);

    localparam int unsigned AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    word_t mem_q [MEM_WORDS];

    assign rdata_o = mem_q[req_i.addr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (req_i.req && req_i.we)
            mem_q[req_i.addr[AW-1:0]] <= req_i.wdata;
    end

endmodule

`default_nettype wire

// File: include/tb_rv_model.svh
// included inside tb_soc_core; needs PROG_LEN, DATA_BASE, DATA_WORDS and the core package types
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

typedef enum int {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR,
    K_ADDI, K_LW, K_SW, K_BEQ, K_BNE, K_JAL
} kind_e;

logic [31:0] rng_state = 32'h918c90b8;
kind_e       kind_a [PROG_LEN];
int          rd_a [PROG_LEN];
int          rs1_a [PROG_LEN];
int          rs2_a [PROG_LEN];
int          imm_a [PROG_LEN];
word_t       prog_a [PROG_LEN];
word_t       data_init [DATA_WORDS];
word_t       model_data [DATA_WORDS];
word_t       model_rf [32];
wb_t         exp_q [$];

function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
endfunction

function automatic int rand_below(int n);
    return int'(next_rand() % n);
endfunction

// RV32I encodings written from the ISA tables
function automatic word_t encode(kind_e k, int rd, int rs1, int rs2, int imm);
    logic [31:0] im;
    logic [4:0]  d;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [2:0]  f3;
    word_t       w;
    im = imm;
    d  = rd[4:0];
    s1 = rs1[4:0];
    s2 = rs2[4:0];
    case (k)
        K_XOR:      f3 = 3'b100;
        K_OR:       f3 = 3'b110;
        K_AND:      f3 = 3'b111;
        K_BNE:      f3 = 3'b001;
        K_LW, K_SW: f3 = 3'b010;
        default:    f3 = 3'b000;
    endcase
    case (k)
        K_ADDI:       w = {im[11:0], s1, f3, d, 7'b0010011};
        K_LW:         w = {im[11:0], s1, f3, d, 7'b0000011};
        K_SW:         w = {im[11:5], s2, s1, f3, im[4:0], 7'b0100011};
        K_BEQ, K_BNE: w = {im[12], im[10:5], s2, s1, f3, im[4:1], im[11], 7'b1100011};
        K_JAL:        w = {im[20], im[10:1], im[11], im[19:12], d, 7'b1101111};
        default:      w = {(k == K_SUB) ? 7'b0100000 : 7'b0000000, s2, s1, f3, d, 7'b0110011};
    endcase
    return w;
endfunction

// prologue sets x1..x7, epilogue is ADDI x1,x1,1 then JAL x0 to itself
task automatic gen_program();
    int last_rd;
    int pick;
    int span;
    last_rd = 1;
    for (int i = 0; i < PROG_LEN; i++) begin
        rd_a[i]   = rand_below(8);
        rs1_a[i]  = rand_below(8);
        rs2_a[i]  = rand_below(8);
        imm_a[i]  = rand_below(4096) - 2048;
        span      = (PROG_LEN - 2 - i > 4) ? 4 : PROG_LEN - 2 - i;
        kind_a[i] = K_ADDI;
        if (i < 7) begin
            rd_a[i]  = i + 1;
            rs1_a[i] = 0;
        end else if (i == PROG_LEN - 2) begin
            rd_a[i]  = 1;
            rs1_a[i] = 1;
            imm_a[i] = 1;
        end else if (i == PROG_LEN - 1) begin
            kind_a[i] = K_JAL;
            rd_a[i]   = 0;
            imm_a[i]  = 0;
        end else begin
            pick = rand_below(16);
            // half the time consume the previous result right away
            if ((next_rand() & 32'd1) != 0)
                rs1_a[i] = last_rd;
            if (pick < 5) begin
                kind_a[i] = kind_e'(pick);
            end else if (pick >= 7 && pick < 11) begin
                kind_a[i] = (pick < 9) ? K_LW : K_SW;
                rs2_a[i]  = rs1_a[i];
                rs1_a[i]  = 0;
                imm_a[i]  = DATA_BASE + 4 * rand_below(DATA_WORDS);
            end else if (pick >= 11) begin
                kind_a[i] = (pick == 12) ? K_BNE : ((pick < 14) ? K_BEQ : K_JAL);
                if (rand_below(3) == 0)
                    rs2_a[i] = rs1_a[i];
                imm_a[i] = 4 * (1 + rand_below(span));
            end
        end
        if (kind_a[i] != K_SW && kind_a[i] != K_BEQ && kind_a[i] != K_BNE)
            last_rd = rd_a[i];
        prog_a[i] = encode(kind_a[i], rd_a[i], rs1_a[i], rs2_a[i], imm_a[i]);
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
        data_init[i]  = next_rand();
        model_data[i] = data_init[i];
    end
endtask

// in-order reference; stops at the final self jump
task automatic run_model();
    int    pc;
    int    nxt;
    word_t a;
    word_t b;
    word_t res;
    logic  wr;
    wb_t   rec;
    exp_q.delete();
    model_rf[0] = '0;
    pc = 0;
    while (pc < PROG_LEN - 1) begin
        a   = model_rf[rs1_a[pc]];
        b   = model_rf[rs2_a[pc]];
        res = '0;
        wr  = 1'b1;
        nxt = pc + 1;
        case (kind_a[pc])
            K_ADD:  res = a + b;
            K_SUB:  res = a - b;
            K_AND:  res = a & b;
            K_OR:   res = a | b;
            K_XOR:  res = a ^ b;
            K_ADDI: res = a + word_t'(imm_a[pc]);
            K_LW:   res = model_data[(imm_a[pc] - DATA_BASE) / 4];
            K_SW: begin
                model_data[(imm_a[pc] - DATA_BASE) / 4] = b;
                wr = 1'b0;
            end
            K_BEQ: begin
                wr = 1'b0;
                if (a == b)
                    nxt = pc + imm_a[pc] / 4;
            end
            K_BNE: begin
                wr = 1'b0;
                if (a != b)
                    nxt = pc + imm_a[pc] / 4;
            end
            default: begin
                res = word_t'(4 * pc + 4);
                nxt = pc + imm_a[pc] / 4;
            end
        endcase
        if (wr && rd_a[pc] != 0) begin
            model_rf[rd_a[pc]] = res;
            rec.valid = 1'b1;
            rec.rd    = reg_addr_t'(rd_a[pc]);
            rec.data  = res;
            exp_q.push_back(rec);
        end
        pc = nxt;
    end
endtask

`endif

// File: verification/tb_soc_core.sv
// programs at word 0 with RESET_PC 0; data window of 16 words at byte 0x400; RAM of 1024 words
`timescale 1ns/100ps
`default_nettype none

module tb_soc_core import rv_core_pkg::*; ();

    localparam int CLK_PERIOD      = 40;
    localparam int MEM_WORDS       = 1024;
    localparam int PROG_LEN        = 32;
    localparam int NUM_PROGS       = 8;
    localparam int DATA_BASE       = 1024;
    localparam int DATA_WORDS      = 16;
    localparam int WATCHDOG_CYCLES = 60 * PROG_LEN * NUM_PROGS + 10;

    logic     clk;
    logic     arst_n_i;
    logic     run_i;
    mem_req_t host_req_i;
    word_t    host_rdata_o;
    wb_t      retire_o;
    int       errors;
    int       checks;
    int       retired;
    wb_t      exp_rec;

    `include "tb_rv_model.svh"

    soc_core_top #(
        .MEM_WORDS(MEM_WORDS),
        .RESET_PC ('0)
    ) dut (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .run_i        (run_i),
        .host_req_i   (host_req_i),
        .host_rdata_o (host_rdata_o),
        .retire_o     (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_wb(input wb_t got, input wb_t exp);
        checks++;
        if (got !== exp) begin
            $display("error retire_o: rd %h data %h, expected rd %h data %h",
                     got.rd, got.data, exp.rd, exp.data);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic host_write(input int addr, input word_t data);
        @(negedge clk);
        host_req_i.req   = 1'b1;
        host_req_i.we    = 1'b1;
        host_req_i.addr  = word_t'(addr);
        host_req_i.wdata = data;
    endtask

    // registered read data is stable by the following falling edge
    task automatic host_read(input int addr, output word_t data);
        @(negedge clk);
        host_req_i.req   = 1'b1;
        host_req_i.we    = 1'b0;
        host_req_i.addr  = word_t'(addr);
        host_req_i.wdata = '0;
        @(negedge clk);
        host_req_i = '0;
        data = host_rdata_o;
    endtask

    task automatic host_idle();
        @(negedge clk);
        host_req_i = '0;
    endtask

    task automatic run_host_test();
        int    addr [8];
        word_t wdat [8];
        word_t got;
        int    err0;
        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            addr[i] = 600 + 50 * i + rand_below(50);
            wdat[i] = next_rand();
            host_write(addr[i], wdat[i]);
        end
        for (int i = 0; i < 8; i++) begin
            host_read(addr[i], got);
            check_word($sformatf("host_rdata_o @%h", addr[i]), got, wdat[i]);
        end
        host_idle();
        $display("test 0 host port: 8 words, %0d errors", errors - err0);
    endtask

    task automatic run_program(input int t);
        word_t got;
        int    err0;
        int    ret0;
        int    n_exp;
        err0 = errors;
        ret0 = retired;
        gen_program();
        run_model();
        n_exp = exp_q.size();
        // two zero words past the end decode as bubbles
        for (int i = 0; i < PROG_LEN + 2; i++)
            host_write(i, (i < PROG_LEN) ? prog_a[i] : 32'd0);
        for (int i = 0; i < DATA_WORDS; i++)
            host_write(DATA_BASE / 4 + i, data_init[i]);
        host_idle();
        run_i = 1'b1;
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);
        run_i = 1'b0;
        repeat (4) @(negedge clk);
        for (int i = 0; i < DATA_WORDS; i++) begin
            host_read(DATA_BASE / 4 + i, got);
            check_word($sformatf("host_rdata_o @%h", DATA_BASE / 4 + i), got, model_data[i]);
        end
        $display("test %0d program: %0d retired of %0d expected, %0d errors",
                 t, retired - ret0, n_exp, errors - err0);
    endtask

    // retire_o is sampled before the edge updates it
    always @(posedge clk) begin
        if (arst_n_i && retire_o.valid) begin
            retired++;
            if (!run_i) begin
                $display("retire of x%0d seen while run_i is low", retire_o.rd);
                errors++;
            end else if (exp_q.size() == 0) begin
                $display("retire of x%0d seen with no further retire expected", retire_o.rd);
                errors++;
            end else begin
                exp_rec = exp_q.pop_front();
                check_wb(retire_o, exp_rec);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        arst_n_i   = 1'b0;
        run_i      = 1'b0;
        host_req_i = '0;
        errors     = 0;
        checks     = 0;
        retired    = 0;
        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;
        run_host_test();
        for (int t = 1; t <= NUM_PROGS; t++)
            run_program(t);
        $display("summary: %0d tests, %0d checks, %0d errors", NUM_PROGS + 1, checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hw/rv_core_pkg.sv
hw/unified_ram.sv
hw/mem_arbiter.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/exec_unit.sv
hw/mem_stage.sv
hw/soc_core_top.sv
verification/tb_soc_core.sv
